//--- Bender.yml
package:
  name: platform_shim

sources:
  - include_dirs:
      - logic
    files:
      - logic/ccip_shim_pkg.sv
      - logic/host_chan_as_ccip.sv
      - logic/ccip_std_afu.sv
      - logic/local_mem_bank.sv
      - logic/platform_shim_ccip_std_afu.sv
      - verif/platform_shim_chk.sv
      - verif/platform_shim_tb.sv

//--- files.f
+incdir+logic
logic/ccip_shim_pkg.sv
logic/host_chan_as_ccip.sv
logic/ccip_std_afu.sv
logic/local_mem_bank.sv
logic/platform_shim_ccip_std_afu.sv
verif/platform_shim_chk.sv
verif/platform_shim_tb.sv

//--- logic/ccip_shim_macros.svh
`ifndef CCIP_SHIM_MACROS_SVH
`define CCIP_SHIM_MACROS_SVH

// Host MMIO geometry as seen by the shim and the AFU
`define MMIO_ADDR_WIDTH 16
`define MMIO_DATA_WIDTH 64
`define MMIO_TID_WIDTH 9

// Word address into the single local memory bank, 256 words deep
`define LOCAL_MEM_ADDR_WIDTH 8

// Value returned by the AFU identifier register
`define AFU_ID_VALUE 64'h5c3a_1e07_b41f_7c0e

// AFU register map, byte offsets on 64 bit boundaries
`define CSR_AFU_ID 16'h0000
`define CSR_SCRATCH 16'h0008
`define CSR_MEM_ADDR 16'h0010
`define CSR_MEM_DATA 16'h0018
`define CSR_PWR_STATE 16'h0020

`endif

//--- logic/ccip_shim_pkg.sv
`include "ccip_shim_macros.svh"

package ccip_shim_pkg;

    // ============================
    // Platform side types
    // ============================

    // Two bit platform power state, passed to the AFU after synchronization
    typedef logic [1:0] t_power_state;

    // Host to shim signals of a Wishbone classic cycle
    typedef struct packed
    {
        logic cyc;
        logic stb;
        logic we;
        logic [`MMIO_ADDR_WIDTH-1:0] adr;
        logic [`MMIO_DATA_WIDTH-1:0] dat;
    } t_wb_req;

    // Shim to host signals, dat only meaningful while ack is high
    typedef struct packed
    {
        logic ack;
        logic [`MMIO_DATA_WIDTH-1:0] dat;
    } t_wb_rsp;

    // ============================
    // CCI-P MMIO types
    // ============================

    // Header of an MMIO request, the tid ties a read to its response
    typedef struct packed
    {
        logic [`MMIO_ADDR_WIDTH-1:0] address;
        logic [`MMIO_TID_WIDTH-1:0] tid;
    } t_ccip_mmio_hdr;

    // Receive channel 0 carries MMIO reads and writes only
    typedef struct packed
    {
        logic mmio_rd_valid;
        logic mmio_wr_valid;
        t_ccip_mmio_hdr hdr;
        logic [`MMIO_DATA_WIDTH-1:0] data;
    } t_ccip_c0_rx;

    // Transmit channel 2 returns MMIO read data with the request tid
    typedef struct packed
    {
        logic mmio_rd_valid;
        logic [`MMIO_TID_WIDTH-1:0] tid;
        logic [`MMIO_DATA_WIDTH-1:0] data;
    } t_ccip_c2_tx;

    // ============================
    // Local memory types
    // ============================

    // AFU command to the bank, held until waitrequest is low
    typedef struct packed
    {
        logic [`LOCAL_MEM_ADDR_WIDTH-1:0] address;
        logic read;
        logic write;
        logic [`MMIO_DATA_WIDTH-1:0] writedata;
    } t_avmm_req;

    // Bank back-pressure and read return
    typedef struct packed
    {
        logic waitrequest;
        logic [`MMIO_DATA_WIDTH-1:0] readdata;
        logic readdatavalid;
    } t_avmm_rsp;

endpackage

//--- logic/ccip_std_afu.sv
`timescale 1ns/100ps
`include "ccip_shim_macros.svh"

module ccip_std_afu
    import ccip_shim_pkg::*;
(
    input  logic         ccip_to_afu,
    input  logic         afu_reset,
    input  t_power_state afu_pwr_state,
    input  t_ccip_c0_rx  c0_rx,
    output t_ccip_c2_tx  c2_tx,
    output t_avmm_req    mem_req,
    input  t_avmm_rsp    mem_rsp
);

    logic [`MMIO_DATA_WIDTH-1:0] scratch;
    logic [`LOCAL_MEM_ADDR_WIDTH-1:0] mem_addr;
    logic mem_rd_wait;
    logic [`MMIO_TID_WIDTH-1:0] mem_rd_tid;
    logic slot_valid;
    logic [`MMIO_TID_WIDTH-1:0] slot_tid;
    logic [`MMIO_DATA_WIDTH-1:0] slot_data;
    logic [`MMIO_DATA_WIDTH-1:0] reg_rd_data;
    logic mem_accept;
    logic mem_busy;
    logic is_mem_data;

    assign is_mem_data = (c0_rx.hdr.address == `CSR_MEM_DATA);
    assign mem_accept = (mem_req.read || mem_req.write) && !mem_rsp.waitrequest;
    // Busy from command issue until a read returns its data
    assign mem_busy = mem_req.read || mem_req.write || mem_rd_wait;

    // ============================
    // Register read decode
    // ============================

    always_comb
    begin
        case (c0_rx.hdr.address)
            `CSR_AFU_ID:    reg_rd_data = `AFU_ID_VALUE;
            `CSR_SCRATCH:   reg_rd_data = scratch;
            `CSR_MEM_ADDR:
                reg_rd_data = {{(`MMIO_DATA_WIDTH-`LOCAL_MEM_ADDR_WIDTH){1'b0}}, mem_addr};
            `CSR_PWR_STATE:
                reg_rd_data = {{(`MMIO_DATA_WIDTH-$bits(t_power_state)){1'b0}}, afu_pwr_state};
            // Undefined offsets read as zero
            default:        reg_rd_data = '0;
        endcase
    end

    // ============================
    // MMIO handling and memory master
    // ============================

    always_ff @(posedge ccip_to_afu)
    begin
        if (afu_reset)
        begin
            scratch <= '0;
            mem_addr <= '0;
            mem_req.read <= 1'b0;
            mem_req.write <= 1'b0;
            mem_rd_wait <= 1'b0;
            slot_valid <= 1'b0;
            c2_tx.mmio_rd_valid <= 1'b0;
        end
        else
        begin
            c2_tx.mmio_rd_valid <= 1'b0;

            // The command is dropped in the cycle the bank takes it
            if (mem_accept)
            begin
                mem_req.read <= 1'b0;
                mem_req.write <= 1'b0;
                if (mem_req.read)
                    mem_rd_wait <= 1'b1;
            end

            // Memory read data goes straight back under its saved tid
            if (mem_rsp.readdatavalid && mem_rd_wait)
            begin
                mem_rd_wait <= 1'b0;
                c2_tx.mmio_rd_valid <= 1'b1;
                c2_tx.tid <= mem_rd_tid;
                c2_tx.data <= mem_rsp.readdata;
            end
            else if (slot_valid && !mem_busy)
            begin
                // A register answer held behind memory traffic leaves now
                slot_valid <= 1'b0;
                c2_tx.mmio_rd_valid <= 1'b1;
                c2_tx.tid <= slot_tid;
                c2_tx.data <= slot_data;
            end

            // Writes to read-only or unknown offsets fall through untouched
            if (c0_rx.mmio_wr_valid)
            begin
                case (c0_rx.hdr.address)
                    `CSR_SCRATCH:  scratch <= c0_rx.data;
                    `CSR_MEM_ADDR: mem_addr <= c0_rx.data[`LOCAL_MEM_ADDR_WIDTH-1:0];
                    `CSR_MEM_DATA:
                    begin
                        mem_req.write <= 1'b1;
                        mem_req.address <= mem_addr;
                        mem_req.writedata <= c0_rx.data;
                    end
                    default: ;
                endcase
            end

            if (c0_rx.mmio_rd_valid)
            begin
                if (is_mem_data)
                begin
                    mem_req.read <= 1'b1;
                    mem_req.address <= mem_addr;
                    mem_rd_tid <= c0_rx.hdr.tid;
                end
                else if (!mem_busy && !slot_valid)
                begin
                    c2_tx.mmio_rd_valid <= 1'b1;
                    c2_tx.tid <= c0_rx.hdr.tid;
                    c2_tx.data <= reg_rd_data;
                end
                else
                begin
                    // Keep responses in order behind an unfinished memory command
                    slot_valid <= 1'b1;
                    slot_tid <= c0_rx.hdr.tid;
                    slot_data <= reg_rd_data;
                end
            end
        end
    end

endmodule

//--- logic/host_chan_as_ccip.sv
`timescale 1ns/100ps
`include "ccip_shim_macros.svh"

module host_chan_as_ccip
    import ccip_shim_pkg::*;
(
    input  logic         ccip_to_afu,
    input  logic         reset,
    input  t_wb_req      wb_req,
    output t_wb_rsp      wb_rsp,
    input  t_power_state pwr_state,
    output t_ccip_c0_rx  c0_rx,
    input  t_ccip_c2_tx  c2_tx,
    output logic         afu_reset,
    output t_power_state afu_pwr_state
);

    // One host cycle is in flight at a time, so a four state walk is enough
    typedef enum logic [1:0]
    {
        ST_IDLE,
        ST_ISSUE,
        ST_WAIT_RSP,
        ST_ACK
    } t_state;

    t_state state;
    logic [`MMIO_TID_WIDTH-1:0] tid_cnt;
    t_power_state pwr_meta;
    logic rsp_match;

    // A response belongs to us only when its tid matches the issued header
    assign rsp_match = c2_tx.mmio_rd_valid && (c2_tx.tid == c0_rx.hdr.tid);

    // ============================
    // Host cycle to MMIO request
    // ============================

    always_ff @(posedge ccip_to_afu)
    begin
        if (reset)
        begin
            state <= ST_IDLE;
            tid_cnt <= '0;
            c0_rx.mmio_rd_valid <= 1'b0;
            c0_rx.mmio_wr_valid <= 1'b0;
            wb_rsp.ack <= 1'b0;
        end
        else
        begin
            // Request valids are single cycle pulses
            c0_rx.mmio_rd_valid <= 1'b0;
            c0_rx.mmio_wr_valid <= 1'b0;

            case (state)
                ST_IDLE:
                begin
                    if (wb_req.cyc && wb_req.stb)
                    begin
                        // Capture the cycle and tag it with the next tid
                        c0_rx.mmio_rd_valid <= !wb_req.we;
                        c0_rx.mmio_wr_valid <= wb_req.we;
                        c0_rx.hdr.address <= wb_req.adr;
                        c0_rx.hdr.tid <= tid_cnt;
                        c0_rx.data <= wb_req.dat;
                        tid_cnt <= tid_cnt + 1'b1;
                        state <= ST_ISSUE;
                    end
                end

                ST_ISSUE:
                begin
                    // Writes are posted, so they are acknowledged right away
                    if (wb_req.we)
                    begin
                        wb_rsp.ack <= 1'b1;
                        state <= ST_ACK;
                    end
                    else
                    begin
                        state <= ST_WAIT_RSP;
                    end
                end

                ST_WAIT_RSP:
                begin
                    if (rsp_match)
                    begin
                        wb_rsp.ack <= 1'b1;
                        wb_rsp.dat <= c2_tx.data;
                        state <= ST_ACK;
                    end
                end

                default:
                begin
                    // The host drops stb after seeing ack, so return to idle
                    wb_rsp.ack <= 1'b0;
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    // ============================
    // AFU reset and power state
    // ============================

    // One timing register on the reset seen by the AFU
    always_ff @(posedge ccip_to_afu)
    begin
        afu_reset <= reset;
    end

    // Two flop synchronizer for the platform power state
    always_ff @(posedge ccip_to_afu)
    begin
        if (reset)
        begin
            pwr_meta <= '0;
            afu_pwr_state <= '0;
        end
        else
        begin
            pwr_meta <= pwr_state;
            afu_pwr_state <= pwr_meta;
        end
    end

endmodule

//--- logic/local_mem_bank.sv
`timescale 1ns/100ps
`include "ccip_shim_macros.svh"

module local_mem_bank
    import ccip_shim_pkg::*;
(
    input  logic      ccip_to_afu,
    input  logic      reset,
    input  t_avmm_req mem_req,
    output t_avmm_rsp mem_rsp
);

    // Storage is left uninitialized, the AFU writes before it reads
    logic [`MMIO_DATA_WIDTH-1:0] mem [0:(1 << `LOCAL_MEM_ADDR_WIDTH)-1];
    logic accept;

    // A command is taken on any edge where waitrequest is low
    assign accept = (mem_req.read || mem_req.write) && !mem_rsp.waitrequest;

    // ============================
    // Handshake
    // ============================

    always_ff @(posedge ccip_to_afu)
    begin
        if (reset)
        begin
            mem_rsp.waitrequest <= 1'b0;
            mem_rsp.readdatavalid <= 1'b0;
        end
        else
        begin
            // Stall for one cycle after every accepted command
            mem_rsp.waitrequest <= accept;
            mem_rsp.readdatavalid <= accept && mem_req.read;
        end
    end

    // Array access, read data lands one cycle after acceptance
    always_ff @(posedge ccip_to_afu)
    begin
        if (accept && mem_req.write)
            mem[mem_req.address] <= mem_req.writedata;
        if (accept && mem_req.read)
            mem_rsp.readdata <= mem[mem_req.address];
    end

endmodule

//--- logic/platform_shim_ccip_std_afu.sv
`timescale 1ns/100ps
`include "ccip_shim_macros.svh"

module platform_shim_ccip_std_afu
    import ccip_shim_pkg::*;
(
    input  logic         ccip_to_afu,
    input  logic         reset,
    input  t_wb_req      wb_req,
    output t_wb_rsp      wb_rsp,
    input  t_power_state pwr_state
);

    // ============================
    // Channels between the blocks
    // ============================

    t_ccip_c0_rx c0_rx;
    t_ccip_c2_tx c2_tx;
    t_avmm_req mem_req;
    t_avmm_rsp mem_rsp;
    logic afu_reset;
    t_power_state afu_pwr_state;

    // Host side adapter, also source of the AFU reset and power state
    host_chan_as_ccip host_chan_i
    (
        .ccip_to_afu   (ccip_to_afu),
        .reset         (reset),
        .wb_req        (wb_req),
        .wb_rsp        (wb_rsp),
        .pwr_state     (pwr_state),
        .c0_rx         (c0_rx),
        .c2_tx         (c2_tx),
        .afu_reset     (afu_reset),
        .afu_pwr_state (afu_pwr_state)
    );

    ccip_std_afu afu_i
    (
        .ccip_to_afu   (ccip_to_afu),
        .afu_reset     (afu_reset),
        .afu_pwr_state (afu_pwr_state),
        .c0_rx         (c0_rx),
        .c2_tx         (c2_tx),
        .mem_req       (mem_req),
        .mem_rsp       (mem_rsp)
    );

    // The bank leaves reset together with the AFU that drives it
    local_mem_bank mem_bank_i
    (
        .ccip_to_afu (ccip_to_afu),
        .reset       (afu_reset),
        .mem_req     (mem_req),
        .mem_rsp     (mem_rsp)
    );

endmodule

//--- verif/platform_shim_chk.sv
`timescale 1ns/100ps
`include "ccip_shim_macros.svh"

module platform_shim_chk
    import ccip_shim_pkg::*;
(
    input logic        ccip_to_afu,
    input logic        reset,
    input t_wb_req     wb_req,
    input t_wb_rsp     wb_rsp,
    input t_ccip_c0_rx c0_rx,
    input t_ccip_c2_tx c2_tx,
    input t_avmm_req   mem_req
);

    // Number of assertion failures seen so far
    int assert_failures = 0;
    logic rd_pending;

    // One MMIO read is open from its c0 pulse until its c2 answer
    always_ff @(posedge ccip_to_afu)
    begin
        if (reset)
            rd_pending <= 1'b0;
        else if (c0_rx.mmio_rd_valid)
            rd_pending <= 1'b1;
        else if (c2_tx.mmio_rd_valid)
            rd_pending <= 1'b0;
    end

    // ============================
    // Protocol rules
    // ============================

    // Wishbone ack belongs inside an open cycle
    ack_in_cycle: assert property (@(posedge ccip_to_afu) disable iff (reset)
        wb_rsp.ack |-> (wb_req.cyc && wb_req.stb))
    else
    begin
        $error("Wishbone ack is high while cyc or stb is low");
        assert_failures++;
    end

    // A c0 request is of one kind and its valid drops again after a single cycle
    c0_single_pulse: assert property (@(posedge ccip_to_afu) disable iff (reset)
        (c0_rx.mmio_rd_valid || c0_rx.mmio_wr_valid)
        |-> !(c0_rx.mmio_rd_valid && c0_rx.mmio_wr_valid)
            ##1 !(c0_rx.mmio_rd_valid || c0_rx.mmio_wr_valid))
    else
    begin
        $error("c0_rx request is not a single cycle pulse of one kind");
        assert_failures++;
    end

    mem_single_cmd: assert property (@(posedge ccip_to_afu) disable iff (reset)
        !(mem_req.read && mem_req.write))
    else
    begin
        $error("Local memory read and write are both high");
        assert_failures++;
    end

    // An unasked c2 answer would be a protocol error on the host channel
    c2_asked: assert property (@(posedge ccip_to_afu) disable iff (reset)
        c2_tx.mmio_rd_valid |-> rd_pending)
    else
    begin
        $error("c2_tx response without an outstanding MMIO read");
        assert_failures++;
    end

endmodule

bind platform_shim_ccip_std_afu platform_shim_chk chk_i
(
    .ccip_to_afu (ccip_to_afu),
    .reset       (reset),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .c0_rx       (c0_rx),
    .c2_tx       (c2_tx),
    .mem_req     (mem_req)
);

//--- verif/platform_shim_tb.sv
`timescale 1ns/100ps
`include "ccip_shim_macros.svh"

module platform_shim_tb
    import ccip_shim_pkg::*;
();

    localparam int CLK_PERIOD = 8;
    localparam int OP_CYCLES = 20;
    localparam int N_SCRATCH = 16;
    localparam int N_MEM_WR = 24;
    localparam int N_MEM_RD = 24;
    localparam int N_PWR = 6;
    localparam int N_RO = 8;
    localparam int N_ADDR = 8;
    // Host accesses over all tests, with a little room for reset and idle checks
    localparam int NUM_OPS = 8 + 2 * N_SCRATCH + 2 * (N_MEM_WR + N_MEM_RD) + 2 * N_PWR
                             + 7 * N_RO + 2 * N_ADDR;
    localparam int WATCHDOG_NS = NUM_OPS * OP_CYCLES * CLK_PERIOD;

    logic ccip_to_afu;
    logic reset;
    t_wb_req wb_req;
    t_wb_rsp wb_rsp;
    t_power_state pwr_state;

    logic [15:0] lfsr_state;
    int error_count;
    int check_count;
    int test_count;
    int test_errors;
    int test_checks;

    // Reference model of the AFU register file and the local bank
    logic [63:0] model_scratch;
    logic [`LOCAL_MEM_ADDR_WIDTH-1:0] model_addr;
    t_power_state model_pwr;
    logic [63:0] model_mem [0:(1 << `LOCAL_MEM_ADDR_WIDTH)-1];
    bit model_written [0:(1 << `LOCAL_MEM_ADDR_WIDTH)-1];
    logic [`LOCAL_MEM_ADDR_WIDTH-1:0] written_addrs [$];

    platform_shim_ccip_std_afu dut_i
    (
        .ccip_to_afu (ccip_to_afu),
        .reset       (reset),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .pwr_state   (pwr_state)
    );

    initial ccip_to_afu = 1'b0;
    always #(CLK_PERIOD / 2) ccip_to_afu = ~ccip_to_afu;

    // ============================
    // Random source
    // ============================

    // Fibonacci LFSR with taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] state);
        logic feedback;
        feedback = state[15] ^ state[13] ^ state[12] ^ state[10];
        return {state[14:0], feedback};
    endfunction

    // One LFSR step for every bit taken
    function automatic logic [63:0] random_bits(input int count);
        logic [63:0] value;
        value = '0;
        for (int i = 0; i < count; i++)
        begin
            lfsr_state = lfsr_step(lfsr_state);
            value = {value[62:0], lfsr_state[0]};
        end
        return value;
    endfunction

    // Aligned offset past the last defined register
    function automatic logic [15:0] undefined_offset();
        logic [63:0] raw;
        logic [15:0] offset;
        raw = random_bits(13);
        offset = {raw[12:0], 3'b000};
        if (offset <= `CSR_PWR_STATE)
            offset = offset + 16'h0028;
        return offset;
    endfunction

    // ============================
    // Host access and reporting
    // ============================

    // A Wishbone classic cycle is held until ack and released one cycle after it
    task automatic wb_access(input logic we, input logic [15:0] adr, input logic [63:0] dat_in,
                             output logic [63:0] dat_out);
        logic got_ack;
        @(negedge ccip_to_afu);
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.we = we;
        wb_req.adr = adr;
        wb_req.dat = dat_in;
        got_ack = 1'b0;
        while (!got_ack)
        begin
            @(negedge ccip_to_afu);
            got_ack = wb_rsp.ack;
        end
        dat_out = wb_rsp.dat;
        @(negedge ccip_to_afu);
        wb_req.cyc = 1'b0;
        wb_req.stb = 1'b0;
        wb_req.we = 1'b0;
    endtask

    task automatic wb_write(input logic [15:0] adr, input logic [63:0] dat);
        logic [63:0] unused;
        wb_access(1'b1, adr, dat, unused);
    endtask

    task automatic wb_read(input logic [15:0] adr, output logic [63:0] dat);
        wb_access(1'b0, adr, '0, dat);
    endtask

    task automatic compare_word(input string test_name, input logic [63:0] expected,
                                input logic [63:0] actual);
        check_count++;
        test_checks++;
        if (actual !== expected)
        begin
            error_count++;
            test_errors++;
            $display("[ERROR] %s: expected 0x%016h, actual 0x%016h",
                     test_name, expected, actual);
        end
    endtask

    task automatic finish_test(input string test_name);
        test_count++;
        $display("[TEST] %-12s checks %0d, errors %0d", test_name, test_checks, test_errors);
        test_checks = 0;
        test_errors = 0;
    endtask

    // ============================
    // Watchdog
    // ============================

    initial
    begin
        #(WATCHDOG_NS);
        $display("[ERROR] Watchdog expired after %0d ns before the tests finished", WATCHDOG_NS);
        $display("Simulation failed");
        $finish;
    end

    // ============================
    // Test sequence
    // ============================

    initial
    begin
        logic [63:0] rd_data;
        logic [63:0] wr_data;
        logic [`LOCAL_MEM_ADDR_WIDTH-1:0] addr;
        logic [15:0] target;
        int idx;
        int total_errors;

        lfsr_state = 16'd37;
        reset = 1'b1;
        wb_req = '0;
        pwr_state = '0;
        error_count = 0;
        check_count = 0;
        test_count = 0;
        test_errors = 0;
        test_checks = 0;
        model_scratch = '0;
        model_addr = '0;
        model_pwr = '0;
        repeat (2) @(negedge ccip_to_afu);
        reset = 1'b0;

        // No open cycle, so the shim must stay silent
        repeat (4)
        begin
            @(negedge ccip_to_afu);
            check_count++;
            test_checks++;
            if (wb_rsp.ack !== 1'b0)
            begin
                error_count++;
                test_errors++;
                $display("[ERROR] after_reset: ack went high although no cycle was open");
            end
        end
        wb_read(`CSR_AFU_ID, rd_data);
        compare_word("after_reset", `AFU_ID_VALUE, rd_data);
        finish_test("after_reset");

        for (int i = 0; i < N_SCRATCH; i++)
        begin
            wr_data = random_bits(64);
            wb_write(`CSR_SCRATCH, wr_data);
            model_scratch = wr_data;
            wb_read(`CSR_SCRATCH, rd_data);
            compare_word("scratch", model_scratch, rd_data);
        end
        finish_test("scratch");

        // Each data write lands at the address written just before it
        for (int i = 0; i < N_MEM_WR; i++)
        begin
            addr = random_bits(`LOCAL_MEM_ADDR_WIDTH);
            wr_data = random_bits(64);
            wb_write(`CSR_MEM_ADDR, {56'b0, addr});
            wb_write(`CSR_MEM_DATA, wr_data);
            model_addr = addr;
            model_mem[addr] = wr_data;
            if (!model_written[addr])
                written_addrs.push_back(addr);
            model_written[addr] = 1'b1;
        end
        for (int i = 0; i < N_MEM_RD; i++)
        begin
            idx = int'(random_bits(8)) % written_addrs.size();
            addr = written_addrs[idx];
            wb_write(`CSR_MEM_ADDR, {56'b0, addr});
            model_addr = addr;
            wb_read(`CSR_MEM_DATA, rd_data);
            compare_word("local_memory", model_mem[addr], rd_data);
        end
        finish_test("local_memory");

        // Hold long enough for the two flop synchronizer
        for (int i = 0; i < N_PWR; i++)
        begin
            @(negedge ccip_to_afu);
            pwr_state = random_bits(2);
            model_pwr = pwr_state;
            repeat (4) @(negedge ccip_to_afu);
            wb_read(`CSR_PWR_STATE, rd_data);
            compare_word("power_state", {62'b0, model_pwr}, rd_data);
        end
        finish_test("power_state");

        for (int i = 0; i < N_RO; i++)
        begin
            case (random_bits(2))
                0: target = `CSR_AFU_ID;
                1: target = `CSR_PWR_STATE;
                default: target = undefined_offset();
            endcase
            wb_write(target, random_bits(64));
            wb_read(`CSR_AFU_ID, rd_data);
            compare_word("read_only", `AFU_ID_VALUE, rd_data);
            wb_read(`CSR_SCRATCH, rd_data);
            compare_word("read_only", model_scratch, rd_data);
            wb_read(`CSR_MEM_ADDR, rd_data);
            compare_word("read_only", {56'b0, model_addr}, rd_data);
            wb_read(`CSR_PWR_STATE, rd_data);
            compare_word("read_only", {62'b0, model_pwr}, rd_data);
            wb_read(undefined_offset(), rd_data);
            compare_word("read_only", 64'b0, rd_data);
            if (model_written[model_addr])
            begin
                wb_read(`CSR_MEM_DATA, rd_data);
                compare_word("read_only", model_mem[model_addr], rd_data);
            end
        end
        finish_test("read_only");

        // Upper address bits are dropped by the register
        for (int i = 0; i < N_ADDR; i++)
        begin
            wr_data = random_bits(64);
            wb_write(`CSR_MEM_ADDR, wr_data);
            model_addr = wr_data[`LOCAL_MEM_ADDR_WIDTH-1:0];
            wb_read(`CSR_MEM_ADDR, rd_data);
            compare_word("mem_address", {56'b0, model_addr}, rd_data);
        end
        finish_test("mem_address");

        total_errors = error_count + dut_i.chk_i.assert_failures;
        $display("Tests %0d, checks %0d, check errors %0d, assertion failures %0d",
                 test_count, check_count, error_count, dut_i.chk_i.assert_failures);
        if (total_errors == 0)
            $display("Simulation passed");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
